// File: spatial_dcache.f
rtl/cache_pkg.sv
rtl/cache_lines.sv
rtl/main_memory.sv
rtl/load_align.sv
rtl/spatial_dcache.sv
+incdir+verification
verification/spatial_dcache_tb.sv

// File: Makefile
# Verilator build and run of the spatial data cache testbench
# every variable can be overridden, e.g. make test LOG=run1.log

TOP       ?= spatial_dcache_tb
FILELIST  ?= spatial_dcache.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= all tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: TOP FILELIST BUILD_DIR LOG VERILATOR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/spatial_dcache_tests.svh
//########################################
// directed tests of the data cache, included in the testbench top
// each task drives the dut and checks against the model
//########################################

`ifndef SPATIAL_DCACHE_TESTS_SVH
`define SPATIAL_DCACHE_TESTS_SVH

// idle after reset, then preload all of memory with writes, then a first read
task automatic test_quiet_cycles();
    int                    e0;
    logic [addr_width-1:0] a;
    e0 = errors;
    repeat (4) idle_op();
    for (int w = 0; w < preload_ops; w++) begin
        a = addr_width'(w * bytes_per_word);
        write_op(a, size_word, {fill_byte(int'(a) + 3), fill_byte(int'(a) + 2),
                                fill_byte(int'(a) + 1), fill_byte(int'(a))});
    end
    idle_op();
    read_expect('0, size_word, 1'b1, model_read('0, size_word));  // valid bits all clear
    report_test("quiet_cycles", e0);
endtask

// four words into one block, first read fills, the rest hit
task automatic test_spatial_fill();
    int                    e0;
    logic [addr_width-1:0] base;
    logic [data_width-1:0] words [words_per_line];
    e0   = errors;
    base = 12'h140;  // set 4, tag 1
    for (int w = 0; w < words_per_line; w++) begin
        words[w] = 32'hc0de_0000 + 32'(w * 32'h111);
        write_op(base + addr_width'(w * 4), size_word, words[w]);
    end
    read_expect(base, size_word, 1'b1, words[0]);
    for (int w = 1; w < words_per_line; w++)
        read_expect(base + addr_width'(w * 4), size_word, 1'b0, words[w]);
    report_test("spatial_fill", e0);
endtask

// bytes at 0..3 and halves at 0,2, each in its own set, first pass miss then hit
task automatic test_narrow_reads();
    int                    e0;
    logic [addr_width-1:0] a;
    access_size_t          s;
    e0 = errors;
    for (int pass = 0; pass < 2; pass++) begin
        for (int k = 0; k < 6; k++) begin
            s = (k < 4) ? size_byte : size_half;
            a = 12'h300 + addr_width'(k * 16) + addr_width'((k < 4) ? k : (k - 4) * 2);
            read_expect(a, s, pass == 0, model_read(a, s));
        end
    end
    report_test("narrow_reads", e0);
endtask

// byte store into a cached word, then into an uncached block
task automatic test_byte_write_through();
    int                    e0;
    logic [data_width-1:0] old;
    e0  = errors;
    old = model_read(12'h300, size_word);  // block 0x300 cached by the narrow test
    write_op(12'h302, size_byte, 32'h0000_00a5);
    read_expect(12'h300, size_word, 1'b0, {old[31:24], 8'ha5, old[15:0]});
    old = model_read(12'h7a0, size_word);
    write_op(12'h7a1, size_byte, 32'h0000_005c);  // no allocate here
    read_expect(12'h7a0, size_word, 1'b1, {old[31:16], 8'h5c, old[7:0]});
    report_test("byte_write_through", e0);
endtask

// same set 11, tags 4 and 8, every read evicts the other
task automatic test_set_conflict();
    int e0;
    e0 = errors;
    repeat (3) begin
        read_expect(12'h4b4, size_word, 1'b1, model_read(12'h4b4, size_word));
        read_expect(12'h8b8, size_word, 1'b1, model_read(12'h8b8, size_word));
    end
    report_test("set_conflict", e0);
endtask

// lcg traffic in the low 512 bytes, two tags per set so hits and evictions mix
task automatic test_random_traffic();
    int                    e0;
    logic [addr_width-1:0] a;
    logic [31:0]           r;
    access_size_t          s;
    e0 = errors;
    for (int n = 0; n < random_ops; n++) begin
        lcg_state = lcg_next(lcg_state);
        r         = lcg_state;
        a         = addr_width'(r[24:16]);
        if (r[28]) begin
            s = r[29] ? size_byte : size_word;
            if (s == size_word)
                a[1:0] = 2'b00;
            lcg_state = lcg_next(lcg_state);
            write_op(a, s, lcg_state);
        end else begin
            case (r[30:29])
                2'd1:    s = size_byte;
                2'd2:    s = size_half;
                default: s = size_word;
            endcase
            if (s == size_word)
                a[1:0] = 2'b00;
            else if (s == size_half)
                a[0] = 1'b0;
            read_model(a, s);
        end
    end
    idle_op();
    report_test("random_traffic", e0);
endtask

`endif

// File: verification/spatial_dcache_tb.sv
//########################################
// testbench top for the spatial data cache
// clock, reset, watchdog, reference model and compare tasks
// directed tests are pulled in from the .svh
//########################################

module spatial_dcache_tb
    import cache_pkg::*;
();

    localparam int addr_width   = 12;
    localparam int set_bits     = 4;
    localparam int tag_width    = addr_width - set_bits - offset_bits;
    localparam int num_sets     = 2 ** set_bits;
    localparam int mem_bytes    = 2 ** addr_width;
    localparam int clk_period   = 10;
    localparam int reset_cycles = 8;
    localparam int preload_ops  = mem_bytes / bytes_per_word;  // one word write each
    localparam int directed_ops = 64;                          // bound over directed tests
    localparam int random_ops   = 200;
    localparam int timeout      = (reset_cycles + preload_ops + directed_ops + random_ops)
                                  * clk_period + 500;

    logic                  clk = 1'b0;
    logic                  rst_n;
    mem_op_t               op;
    logic [addr_width-1:0] addr;
    access_size_t          size;
    logic [data_width-1:0] wdata;
    logic [data_width-1:0] rdata;
    logic                  miss;

    // reference model, memory bytes plus valid/tag per set
    logic [byte_width-1:0] model_mem   [mem_bytes];
    logic                  model_valid [num_sets];
    logic [tag_width-1:0]  model_tag   [num_sets];
    logic [31:0]           lcg_state = 32'd3522;

    int errors    = 0;
    int checks    = 0;
    int tests_run = 0;

    always #(clk_period / 2) clk = ~clk;

    spatial_dcache #(
        .addr_width (addr_width),
        .set_bits   (set_bits)
    ) i_dut (
        .clk   (clk),
        .rst_n (rst_n),
        .op    (op),
        .addr  (addr),
        .size  (size),
        .wdata (wdata),
        .rdata (rdata),
        .miss  (miss)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // memory image, every address bit feeds the byte
    function automatic logic [byte_width-1:0] fill_byte(input int a);
        return byte_width'((a * 37) ^ (a >> 4));
    endfunction

    function automatic logic model_hit(input logic [addr_width-1:0] a);
        logic [set_bits-1:0] s;
        s = a[offset_bits +: set_bits];
        return model_valid[s] && (model_tag[s] == a[addr_width-1 -: tag_width]);
    endfunction

    // little-endian load, zero-extended
    function automatic logic [data_width-1:0] model_read(input logic [addr_width-1:0] a,
                                                         input access_size_t s);
        int i;
        i = int'(a);
        case (s)
            size_byte: return data_width'(model_mem[i]);
            size_half: return data_width'({model_mem[i+1], model_mem[i]});
            default:   return {model_mem[i+3], model_mem[i+2], model_mem[i+1], model_mem[i]};
        endcase
    endfunction

    task automatic model_write(input logic [addr_width-1:0] a, input access_size_t s,
                               input logic [data_width-1:0] d);
        if (s == size_byte) begin
            model_mem[int'(a)] = d[byte_width-1:0];
        end else begin
            for (int b = 0; b < bytes_per_word; b++)
                model_mem[int'(a) + b] = d[b*byte_width +: byte_width];
        end
    endtask

    task automatic model_fill(input logic [addr_width-1:0] a);
        model_valid[a[offset_bits +: set_bits]] = 1'b1;
        model_tag[a[offset_bits +: set_bits]]   = a[addr_width-1 -: tag_width];
    endtask

    task automatic check_data(input logic [data_width-1:0] expected,
                              input logic [data_width-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail rdata at addr %h: expected %h, got %h", addr, expected, actual);
        end
    endtask

    task automatic check_miss(input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail miss at addr %h: expected %h, got %h", addr, expected, actual);
        end
    endtask

    // drive on the rising edge, outputs are sampled at the falling edge
    task automatic apply_op(input mem_op_t o, input logic [addr_width-1:0] a,
                            input access_size_t s, input logic [data_width-1:0] d);
        @(posedge clk);
        op    <= o;
        addr  <= a;
        size  <= s;
        wdata <= d;
        @(negedge clk);
    endtask

    task automatic read_expect(input logic [addr_width-1:0] a, input access_size_t s,
                               input logic want_miss, input logic [data_width-1:0] want);
        apply_op(op_read, a, s, '0);
        check_data(want, rdata);
        check_miss(want_miss, miss);
        if (!model_hit(a))
            model_fill(a);  // dut fills at the closing edge
    endtask

    task automatic read_model(input logic [addr_width-1:0] a, input access_size_t s);
        read_expect(a, s, !model_hit(a), model_read(a, s));
    endtask

    task automatic write_op(input logic [addr_width-1:0] a, input access_size_t s,
                            input logic [data_width-1:0] d);
        apply_op(op_write, a, s, d);
        check_data('0, rdata);  // quiet during a write
        check_miss(1'b0, miss);
        model_write(a, s, d);
    endtask

    task automatic idle_op();
        apply_op(op_idle, '0, size_word, '0);
        check_data('0, rdata);
        check_miss(1'b0, miss);
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, errors - errs_before);
    endtask

    `include "spatial_dcache_tests.svh"

    initial begin
        rst_n = 1'b0;
        op    = op_idle;
        addr  = '0;
        size  = size_word;
        wdata = '0;
        for (int s = 0; s < num_sets; s++) begin
            model_valid[s] = 1'b0;
            model_tag[s]   = '0;
        end
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;

        test_quiet_cycles();
        test_spatial_fill();
        test_narrow_reads();
        test_byte_write_through();
        test_set_conflict();
        test_random_traffic();

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    // watchdog, sized from the op counts above
    initial begin
        #(timeout);
        $display("run timed out after %0d time units, the test sequence never finished",
                 timeout);
        $display("tests failed");
        $finish;
    end

endmodule

// File: rtl/spatial_dcache.sv
//######################################
// direct-mapped write-through data cache with block prefetch
// top level for the load/store path, one op per cycle
//######################################

module spatial_dcache
    import cache_pkg::*;
#(
    parameter int addr_width = 12,  // 4 KB of main memory
    parameter int set_bits   = 4    // 16 sets
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mem_op_t               op,
    input  logic [addr_width-1:0] addr,
    input  access_size_t          size,
    input  logic [data_width-1:0] wdata,
    output logic [data_width-1:0] rdata,
    output logic                  miss
);

    logic [line_width-1:0] mem_block;  // aligned block around addr
    logic [line_width-1:0] line_data;  // cached line of the addressed set
    logic                  hit;

    // line store, fills from mem_block on a read miss
    cache_lines #(
        .addr_width (addr_width),
        .set_bits   (set_bits)
    ) u_lines (
        .clk       (clk),
        .rst_n     (rst_n),
        .op        (op),
        .addr      (addr),
        .size      (size),
        .wdata     (wdata),
        .mem_block (mem_block),
        .line_data (line_data),
        .hit       (hit),
        .miss      (miss)
    );

    // every write lands here as well
    main_memory #(
        .addr_width (addr_width)
    ) u_mem (
        .clk       (clk),
        .op        (op),
        .addr      (addr),
        .size      (size),
        .wdata     (wdata),
        .mem_block (mem_block)
    );

    load_align #(
        .addr_width (addr_width)
    ) u_align (
        .op        (op),
        .addr      (addr),
        .size      (size),
        .hit       (hit),
        .line_data (line_data),
        .mem_block (mem_block),
        .rdata     (rdata)
    );

endmodule

// File: rtl/load_align.sv
//######################################
// load data path, picks cached line on a hit or memory block on a miss
// then selects word, half or byte and zero-extends
//######################################

module load_align
    import cache_pkg::*;
#(
    parameter int addr_width = 12
) (
    input  mem_op_t               op,
    input  logic [addr_width-1:0] addr,
    input  access_size_t          size,
    input  logic                  hit,
    input  logic [line_width-1:0] line_data,
    input  logic [line_width-1:0] mem_block,
    output logic [data_width-1:0] rdata
);

    logic [line_width-1:0]    src_line;
    logic [data_width-1:0]    word;
    logic [word_off_bits-1:0] word_sel;
    logic [byte_off_bits-1:0] byte_sel;

    assign src_line = hit ? line_data : mem_block;  // miss reads straight from memory
    assign word_sel = addr[offset_bits-1:byte_off_bits];
    assign byte_sel = addr[byte_off_bits-1:0];
    assign word     = src_line[word_sel*data_width +: data_width];

    always_comb begin
        rdata = '0;  // quiet unless reading
        if (op == op_read) begin
            case (size)
                size_word: rdata = word;
                size_half: begin
                    // upper bit of byte offset chooses the halfword
                    rdata[half_width-1:0] = word[byte_sel[1]*half_width +: half_width];
                end
                size_byte: rdata[byte_width-1:0] = word[byte_sel*byte_width +: byte_width];
                default:   rdata = '0;
            endcase
        end
    end

    // write-through keeps a hit line identical to memory
    always_comb begin
        a_line_coherent: assert final (!(op == op_read && hit === 1'b1) ||
                                       line_data === mem_block);
    end

endmodule

// File: rtl/main_memory.sv
//######################################
// byte-wide backing memory behind the cache
// presents the aligned four-word block of addr, writes at the edge
//######################################

module main_memory
    import cache_pkg::*;
#(
    parameter int addr_width = 12
) (
    input  logic                  clk,
    input  mem_op_t               op,
    input  logic [addr_width-1:0] addr,
    input  access_size_t          size,
    input  logic [data_width-1:0] wdata,
    output logic [line_width-1:0] mem_block
);

    localparam int depth       = 2 ** addr_width;
    localparam int block_bytes = line_width / byte_width;  // 16

    // contents are not reset, they hold whatever was written
    logic [byte_width-1:0] mem [depth];

    // block read, byte i of the block lands in bits i*8 upward
    always_comb begin
        for (int i = 0; i < block_bytes; i++) begin
            mem_block[i*byte_width +: byte_width] =
                mem[{addr[addr_width-1:offset_bits], offset_bits'(i)}];
        end
    end

    always_ff @(posedge clk) begin
        if (op == op_write) begin
            if (size == size_byte) begin
                mem[addr] <= wdata[byte_width-1:0];
            end else begin
                // little-endian, lsb byte at the lowest address
                for (int b = 0; b < bytes_per_word; b++) begin
                    mem[addr + addr_width'(b)] <= wdata[b*byte_width +: byte_width];
                end
            end
        end
    end

    // the line store only merges within one block
    a_word_in_block: assert property (@(posedge clk)
        (op == op_write && size == size_word)
        |-> int'(addr[offset_bits-1:0]) + bytes_per_word <= block_bytes);

endmodule

// File: rtl/cache_lines.sv
//######################################
// line store of the direct-mapped cache
// valid/tag/data per set, hit check, block fill on a read miss
// and write-through merge when the write hits
//######################################

module cache_lines
    import cache_pkg::*;
#(
    parameter int addr_width = 12,
    parameter int set_bits   = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mem_op_t               op,
    input  logic [addr_width-1:0] addr,
    input  access_size_t          size,
    input  logic [data_width-1:0] wdata,
    input  logic [line_width-1:0] mem_block,  // aligned block from main memory
    output logic [line_width-1:0] line_data,
    output logic                  hit,
    output logic                  miss
);

    localparam int tag_width = addr_width - set_bits - offset_bits;
    localparam int num_sets  = 2 ** set_bits;

    logic [num_sets-1:0]   valid_q;               // cleared by reset
    logic [tag_width-1:0]  tag_mem  [num_sets];
    logic [line_width-1:0] data_mem [num_sets];

    // address fields tag | set | word | byte
    logic [set_bits-1:0]      set_idx;
    logic [tag_width-1:0]     addr_tag;
    logic [word_off_bits-1:0] word_sel;
    logic [byte_off_bits-1:0] byte_sel;
    logic [line_width-1:0]    merged_line;

    assign byte_sel = addr[byte_off_bits-1:0];
    assign word_sel = addr[offset_bits-1:byte_off_bits];
    assign set_idx  = addr[offset_bits +: set_bits];
    assign addr_tag = addr[addr_width-1 -: tag_width];

    assign line_data = data_mem[set_idx];
    assign hit  = valid_q[set_idx] && (tag_mem[set_idx] == addr_tag);
    assign miss = (op == op_read) && !hit;  // writes never report a miss

    // store data laid over the current line so only one lane changes
    always_comb begin
        merged_line = line_data;
        if (size == size_byte) begin
            merged_line[word_sel*data_width + byte_sel*byte_width +: byte_width] =
                wdata[byte_width-1:0];
        end else begin
            merged_line[word_sel*data_width +: data_width] = wdata;  // full word
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (miss) begin
            valid_q[set_idx] <= 1'b1;  // set becomes live with the fill
        end
    end

    // fill takes the whole block so neighbours hit afterwards
    always_ff @(posedge clk) begin
        if (miss) begin
            tag_mem[set_idx]  <= addr_tag;
            data_mem[set_idx] <= mem_block;
        end else if (op == op_write && hit) begin
            data_mem[set_idx] <= merged_line;  // no allocate on a write miss
        end
    end

    a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (op != op_idle && size == size_word) |-> byte_sel == '0);

    a_half_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (op == op_read && size == size_half) |-> !byte_sel[0]);

    a_no_half_write: assert property (@(posedge clk) disable iff (!rst_n)
        op == op_write |-> size != size_half);

endmodule

// File: rtl/cache_pkg.sv
//######################################
// shared types and constants for the data cache
// imported by wildcard in every module header
//######################################

package cache_pkg;

    // operation on the load/store port, plain levels
    typedef enum logic [1:0] {
        op_idle  = 2'b00,
        op_read  = 2'b01,
        op_write = 2'b10
    } mem_op_t;

    // access width, same encoding as the core's data type field
    typedef enum logic [1:0] {
        size_word = 2'b00,
        size_byte = 2'b01,
        size_half = 2'b10  // reads only
    } access_size_t;

    // data path widths
    localparam int data_width = 32;
    localparam int byte_width = 8;
    localparam int half_width = 2 * byte_width;

    // line layout: four words side by side, lowest word in the low bits
    localparam int words_per_line = 4;
    localparam int bytes_per_word = data_width / byte_width;
    localparam int line_width     = data_width * words_per_line;  // 128

    // address fields below the set index
    localparam int byte_off_bits = $clog2(bytes_per_word);   // byte within word
    localparam int word_off_bits = $clog2(words_per_line);   // word within line
    localparam int offset_bits   = byte_off_bits + word_off_bits;  // 4

endpackage
